//--- Makefile
SIM        := verilator
TOP        := lsu_tb
FILELIST   := sim.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/lsu_mem_model.sv
// Testbench data bus responder, byte memory with random grant and read-valid delays and error word
`timescale 1ns/1ns

module lsu_mem_model
    import lsu_bus_pkg::*;
#(
    parameter int ADDR_W    = 32,
    parameter int MEM_BYTES = 256
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_req,
    input  logic                i_we,
    input  logic [ADDR_W-1:0]   i_addr,
    input  logic [DATA_W-1:0]   i_wdata,
    input  logic [STRB_W-1:0]   i_wstrb,
    // Error injection for one marked word
    input  logic                i_err_en,
    input  logic [ADDR_W-1:0]   i_err_addr,
    output logic                o_gnt,
    output logic                o_rvalid,
    output logic [DATA_W-1:0]   o_rdata,
    output logic                o_err
);

    localparam int MEM_AW = $clog2(MEM_BYTES);

    logic [7:0]        mem [MEM_BYTES];
    logic [1:0]        r_gnt_wait;
    logic [1:0]        r_rv_wait;
    // Granted access waiting for its read-valid
    logic              r_pending;
    logic [ADDR_W-1:0] r_addr;
    logic              r_err;

    // Grant once the random wait has run out and no access is open
    assign o_gnt = i_req && !r_pending && (r_gnt_wait == 2'd0);

    always @(posedge i_clk or negedge i_rst_n) begin : bus_proc
        int b;
        if (!i_rst_n) begin
            // Fill pattern mixes every address bit
            for (b = 0; b < MEM_BYTES; b++) begin
                mem[b] = 8'(b * 37 + 11);
            end
            r_gnt_wait <= 2'd0;
            r_rv_wait  <= 2'd0;
            r_pending  <= 1'b0;
            r_addr     <= '0;
            r_err      <= 1'b0;
            o_rvalid   <= 1'b0;
            o_rdata    <= '0;
            o_err      <= 1'b0;
        end else begin
            o_rvalid <= 1'b0;
            o_err    <= 1'b0;
            if (i_req && !r_pending && r_gnt_wait != 2'd0) begin
                r_gnt_wait <= r_gnt_wait - 2'd1;
            end
            if (o_gnt) begin
                // Strobed bytes land at grant time
                if (i_we) begin
                    for (b = 0; b < STRB_W; b++) begin
                        if (i_wstrb[b]) begin
                            mem[MEM_AW'(i_addr) + MEM_AW'(b)] = i_wdata[8*b +: 8];
                        end
                    end
                end
                r_pending  <= 1'b1;
                r_addr     <= i_addr;
                r_err      <= i_err_en &&
                              (i_addr[ADDR_W-1:OFFS_W] == i_err_addr[ADDR_W-1:OFFS_W]);
                r_rv_wait  <= 2'($urandom_range(2, 0));
                r_gnt_wait <= 2'($urandom_range(3, 0));
            end else if (r_pending) begin
                if (r_rv_wait == 2'd0) begin
                    o_rvalid  <= 1'b1;
                    o_err     <= r_err;
                    r_pending <= 1'b0;
                    for (b = 0; b < STRB_W; b++) begin
                        o_rdata[8*b +: 8] <= mem[MEM_AW'(r_addr) + MEM_AW'(b)];
                    end
                end else begin
                    r_rv_wait <= r_rv_wait - 2'd1;
                end
            end
        end
    end

endmodule : lsu_mem_model

//--- dv/lsu_tb.sv
// Testbench for the load/store unit, runs directed and random commands against a shadow memory
`timescale 1ns/1ns

module lsu_tb
    import lsu_bus_pkg::*;
    import lsu_op_pkg::*;
();

    localparam int ADDR_W         = 32;
    localparam int MEM_BYTES      = 256;
    localparam int MEM_AW         = 8;
    // Directed commands ahead of the random mix
    localparam int NUM_DIRECTED   = 50;
    localparam int NUM_RANDOM     = 200;
    localparam int NUM_CMDS       = NUM_DIRECTED + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = NUM_CMDS * 20;
    // Word that the responder flags with an error
    localparam logic [ADDR_W-1:0] ERR_WORD = ADDR_W'('h40);

    logic              i_clk;
    logic              i_rst_n;
    logic              cmd_valid;
    logic              cmd_read;
    logic              cmd_write;
    ls_size_e          cmd_size;
    logic [ADDR_W-1:0] cmd_addr;
    logic [DATA_W-1:0] cmd_wdata;
    logic              dbus_req;
    logic              dbus_we;
    logic [ADDR_W-1:0] dbus_addr;
    logic [DATA_W-1:0] dbus_wdata;
    logic [STRB_W-1:0] dbus_wstrb;
    logic              dbus_gnt;
    logic              dbus_rvalid;
    logic [DATA_W-1:0] dbus_rdata;
    logic              dbus_err;
    logic [DATA_W-1:0] rdata;
    logic              busy;
    logic              err;
    logic              err_en;

    logic [7:0]        shadow [MEM_BYTES];
    // Granted bus addresses of the command in flight
    logic [ADDR_W-1:0] acc_addrs [$];
    // Expected results of the command in flight
    logic              exp_read;
    logic [DATA_W-1:0] exp_rdata;
    logic              exp_err;
    int                exp_n_acc;
    logic [ADDR_W-1:0] exp_addr_lo;
    int                n_checks  = 0;
    int                n_errors  = 0;
    int                cmd_count = 0;
    int                cycle_cnt = 0;

    lsu_top #(
        .ADDR_W (ADDR_W)
    ) lsu_top_i (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_valid (cmd_valid), .i_read (cmd_read), .i_write (cmd_write),
        .i_size (cmd_size), .i_addr (cmd_addr), .i_wdata (cmd_wdata),
        .o_dbus_req (dbus_req), .o_dbus_we (dbus_we), .o_dbus_addr (dbus_addr),
        .o_dbus_wdata (dbus_wdata), .o_dbus_wstrb (dbus_wstrb),
        .i_dbus_gnt (dbus_gnt), .i_dbus_rvalid (dbus_rvalid),
        .i_dbus_rdata (dbus_rdata), .i_dbus_err (dbus_err),
        .o_rdata (rdata), .o_busy (busy), .o_err (err)
    );

    lsu_mem_model #(
        .ADDR_W    (ADDR_W),
        .MEM_BYTES (MEM_BYTES)
    ) mem_model_i (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_req (dbus_req), .i_we (dbus_we), .i_addr (dbus_addr),
        .i_wdata (dbus_wdata), .i_wstrb (dbus_wstrb),
        .i_err_en (err_en), .i_err_addr (ERR_WORD),
        .o_gnt (dbus_gnt), .o_rvalid (dbus_rvalid), .o_rdata (dbus_rdata), .o_err (dbus_err)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // ========================================================================
    // Reference model
    // ========================================================================

    function automatic int size_bytes(input ls_size_e size);
        case (size)
            LS_BYTE, LS_BYTE_U: return 1;
            LS_HALF, LS_HALF_U: return 2;
            default:            return 4;
        endcase
    endfunction

    // Byte index wraps like the responder memory
    function automatic logic [MEM_AW-1:0] mem_index(input logic [ADDR_W-1:0] addr, input int k);
        return MEM_AW'(addr) + MEM_AW'(k);
    endfunction

    // Expected load value built from the shadow bytes
    function automatic logic [DATA_W-1:0] ref_load(input logic [ADDR_W-1:0] addr,
                                                   input ls_size_e size);
        logic [DATA_W-1:0] raw;
        int k;
        for (k = 0; k < WORD_BYTES; k++) begin
            raw[8*k +: 8] = shadow[mem_index(addr, k)];
        end
        case (size)
            LS_BYTE:   return {{(DATA_W-8){raw[7]}}, raw[7:0]};
            LS_BYTE_U: return {{(DATA_W-8){1'b0}}, raw[7:0]};
            LS_HALF:   return {{(DATA_W-16){raw[15]}}, raw[15:0]};
            LS_HALF_U: return {{(DATA_W-16){1'b0}}, raw[15:0]};
            default:   return raw;
        endcase
    endfunction

    task automatic shadow_store(input logic [ADDR_W-1:0] addr, input ls_size_e size,
                                input logic [DATA_W-1:0] wdata);
        int k;
        for (k = 0; k < size_bytes(size); k++) begin
            shadow[mem_index(addr, k)] = wdata[8*k +: 8];
        end
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================

    // One command, expectations set with it, returns in the completion cycle
    task automatic run_cmd(input logic wr, input ls_size_e size, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata);
        logic [ADDR_W-1:0] lo_addr;
        logic              crosses;
        lo_addr = {addr[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
        crosses = (int'(addr[OFFS_W-1:0]) + size_bytes(size)) > WORD_BYTES;
        @(negedge i_clk);
        cmd_valid   <= 1'b1;
        cmd_read    <= !wr;
        cmd_write   <= wr;
        cmd_size    <= size;
        cmd_addr    <= addr;
        cmd_wdata   <= wdata;
        exp_read    <= !wr;
        exp_rdata   <= ref_load(addr, size);
        exp_err     <= err_en && (lo_addr == ERR_WORD ||
                       (crosses && lo_addr + ADDR_W'(WORD_BYTES) == ERR_WORD));
        exp_n_acc   <= crosses ? 2 : 1;
        exp_addr_lo <= lo_addr;
        cmd_count++;
        if (wr) begin
            shadow_store(addr, size, wdata);
        end
        do begin
            @(negedge i_clk);
        end while (busy);
    endtask

    initial begin
        ls_size_e sizes [5];
        int       k;
        int       off;
        sizes = '{LS_BYTE, LS_BYTE_U, LS_HALF, LS_HALF_U, LS_WORD};
        void'($urandom(32'h2ddb));
        i_rst_n     = 1'b0;
        cmd_valid   = 1'b0;
        cmd_read    = 1'b0;
        cmd_write   = 1'b0;
        cmd_size    = LS_WORD;
        cmd_addr    = '0;
        cmd_wdata   = '0;
        err_en      = 1'b0;
        exp_read    = 1'b0;
        exp_rdata   = '0;
        exp_err     = 1'b0;
        exp_n_acc   = 1;
        exp_addr_lo = '0;
        // Same fill as the responder memory
        for (k = 0; k < MEM_BYTES; k++) begin
            shadow[k] = 8'(k * 37 + 11);
        end
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n <= 1'b1;

        // Aligned words
        for (k = 0; k < 4; k++) begin
            run_cmd(1'b1, LS_WORD, ADDR_W'(16 + 4 * k), $urandom);
            run_cmd(1'b0, LS_WORD, ADDR_W'(16 + 4 * k), '0);
        end
        // Narrow loads at every offset
        for (k = 0; k < 4; k++) begin
            for (off = 0; off < 4; off++) begin
                run_cmd(1'b0, sizes[k], ADDR_W'(32 + off), '0);
            end
        end
        // Word boundary crossings
        for (off = 1; off < 4; off++) begin
            run_cmd(1'b1, LS_WORD, ADDR_W'(80 + off), $urandom);
            run_cmd(1'b0, LS_WORD, ADDR_W'(80 + off), '0);
        end
        run_cmd(1'b1, LS_HALF, ADDR_W'('h63), $urandom);
        run_cmd(1'b0, LS_HALF, ADDR_W'('h63), '0);
        run_cmd(1'b0, LS_HALF_U, ADDR_W'('h63), '0);
        // Narrow stores leave neighbouring bytes alone
        for (off = 0; off < 4; off++) begin
            run_cmd(1'b1, LS_BYTE, ADDR_W'(112 + off), $urandom);
            run_cmd(1'b0, LS_WORD, ADDR_W'(112), '0);
        end
        run_cmd(1'b1, LS_HALF, ADDR_W'('h76), $urandom);
        run_cmd(1'b0, LS_WORD, ADDR_W'('h74), '0);
        run_cmd(1'b0, LS_WORD, ADDR_W'('h78), '0);
        // Bus errors on single, upper and lower halves
        err_en = 1'b1;
        run_cmd(1'b0, LS_WORD, ADDR_W'('h40), '0);
        run_cmd(1'b0, LS_WORD, ADDR_W'('h3d), '0);
        run_cmd(1'b0, LS_WORD, ADDR_W'('h42), '0);
        run_cmd(1'b1, LS_WORD, ADDR_W'('h40), $urandom);
        run_cmd(1'b0, LS_BYTE, ADDR_W'('h41), '0);
        run_cmd(1'b0, LS_WORD, ADDR_W'('h80), '0);
        err_en = 1'b0;
        // Random mix
        for (k = 0; k < NUM_RANDOM; k++) begin
            err_en = ($urandom_range(3, 0) == 0);
            off    = int'($urandom_range(4, 0));
            run_cmd(1'($urandom_range(1, 0)), sizes[off], ADDR_W'($urandom_range(255, 0)),
                    $urandom);
        end

        @(negedge i_clk);
        cmd_valid <= 1'b0;
        @(negedge i_clk);
        if (n_checks != cmd_count) begin
            $display("Only %0d of %0d commands reached completion", n_checks, cmd_count);
            n_errors++;
        end
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // ========================================================================
    // Monitoring and checks
    // ========================================================================

    always @(posedge i_clk) begin
        if (i_rst_n && dbus_req && dbus_gnt) begin
            acc_addrs.push_back(dbus_addr);
        end
    end

    // Completion cycle is busy low with a valid command
    always @(negedge i_clk) begin
        if (i_rst_n && cmd_valid && !busy) begin
            n_checks++;
            if (exp_read && rdata !== exp_rdata) begin
                $display("FAILED %0t: load %s at %h returned %h, expected %h",
                         $time, cmd_size.name(), cmd_addr, rdata, exp_rdata);
                n_errors++;
            end
            if (err !== exp_err) begin
                $display("FAILED %0t: o_err %b at %h, expected %b", $time, err, cmd_addr, exp_err);
                n_errors++;
            end
            if (acc_addrs.size() != exp_n_acc) begin
                $display("FAILED %0t: %0d bus accesses for %h, expected %0d",
                         $time, acc_addrs.size(), cmd_addr, exp_n_acc);
                n_errors++;
            end else if (acc_addrs[0] !== exp_addr_lo || (exp_n_acc == 2 &&
                         acc_addrs[1] !== exp_addr_lo + ADDR_W'(WORD_BYTES))) begin
                $display("FAILED %0t: wrong bus address order for %h", $time, cmd_addr);
                n_errors++;
            end
            acc_addrs.delete();
        end else if (i_rst_n && err) begin
            $display("FAILED %0t: o_err high outside a completion cycle", $time);
            n_errors++;
        end
    end

    // Run limit in clock cycles
    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("Run did not finish within %0d cycles, busy is %b, errors so far %0d",
                 TIMEOUT_CYCLES, busy, n_errors);
        $display("Checks failed");
        $finish;
    end

endmodule : lsu_tb

//--- sim.f
source/lsu_bus_pkg.sv
source/lsu_op_pkg.sv
source/lsu_store_align.sv
source/lsu_bus_seq.sv
source/lsu_load_align.sv
source/lsu_top.sv
dv/lsu_mem_model.sv
dv/lsu_tb.sv

//--- source/lsu_bus_pkg.sv
// Data bus widths and derived constants, imported by every LSU module and the testbench
package lsu_bus_pkg;

    // ========================================================================
    // Data bus geometry
    // ========================================================================

    // Width of one bus data word
    localparam int DATA_W = 32;

    // One strobe per byte lane
    localparam int STRB_W = DATA_W / 8;

    // Byte offset inside a word
    localparam int OFFS_W = $clog2(STRB_W);

    // Address distance between two neighbouring words
    localparam int WORD_BYTES = STRB_W;

endpackage : lsu_bus_pkg

//--- source/lsu_bus_seq.sv
// Bus sequencer that issues one or two data bus accesses per command and reports completion
`timescale 1ns/1ns

module lsu_bus_seq
    import lsu_bus_pkg::*;
    import lsu_op_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    // Command
    input  logic                i_valid,
    input  logic                i_read,
    input  logic                i_write,
    input  ls_size_e            i_size,
    input  logic [ADDR_W-1:0]   i_addr,
    // Lane-placed store data
    input  logic [DATA_W-1:0]   i_lo_wdata,
    input  logic [STRB_W-1:0]   i_lo_wstrb,
    input  logic [DATA_W-1:0]   i_hi_wdata,
    input  logic [STRB_W-1:0]   i_hi_wstrb,
    // Data bus
    input  logic                i_dbus_gnt,
    input  logic                i_dbus_rvalid,
    input  logic [DATA_W-1:0]   i_dbus_rdata,
    input  logic                i_dbus_err,
    output logic                o_dbus_req,
    output logic                o_dbus_we,
    output logic [ADDR_W-1:0]   o_dbus_addr,
    output logic [DATA_W-1:0]   o_dbus_wdata,
    output logic [STRB_W-1:0]   o_dbus_wstrb,
    // To load aligner and caller
    output logic [DATA_W-1:0]   o_lo_rdata,
    output logic                o_split_hi,
    output logic                o_busy,
    output logic                o_err
);

    // ========================================================================
    // Address split and crossing check
    // ========================================================================

    logic [OFFS_W-1:0] w_offset;
    logic [ADDR_W-1:0] w_addr_lo;
    logic [ADDR_W-1:0] w_addr_hi;
    logic              w_crosses;
    logic              w_is_mem_op;

    assign w_offset  = i_addr[OFFS_W-1:0];
    assign w_addr_lo = {i_addr[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
    assign w_addr_hi = w_addr_lo + ADDR_W'(WORD_BYTES);

    // Byte never crosses, half only from the last lane, word from any nonzero offset
    always_comb begin
        case (i_size)
            LS_HALF, LS_HALF_U: w_crosses = (w_offset == '1);
            LS_WORD:            w_crosses = (w_offset != '0);
            default:            w_crosses = 1'b0;
        endcase
    end

    assign w_is_mem_op = i_valid && (i_read || i_write);

    // ========================================================================
    // State machine
    // ========================================================================

    lsu_state_e        r_state;
    lsu_state_e        w_state_next;
    // Current access already granted, waiting for read-valid
    logic              r_granted;
    logic [DATA_W-1:0] r_lo_rdata;
    // Error seen on the lower half of a split
    logic              r_err_acc;
    logic              w_done;
    logic              w_use_hi;

    always_comb begin
        w_state_next = r_state;
        o_dbus_req   = 1'b0;
        w_done       = 1'b0;
        case (r_state)
            LSU_IDLE: begin
                // Request goes out in the same cycle as the command
                if (w_is_mem_op) begin
                    o_dbus_req   = 1'b1;
                    w_state_next = w_crosses ? LSU_SPLIT_LO : LSU_ALIGNED;
                end
            end
            LSU_SPLIT_LO: begin
                o_dbus_req = !r_granted;
                if (i_dbus_rvalid) begin
                    w_state_next = LSU_SPLIT_HI;
                end
            end
            default: begin
                // Aligned access or upper half, both finish on read-valid
                o_dbus_req = !r_granted;
                if (i_dbus_rvalid) begin
                    w_state_next = LSU_IDLE;
                    w_done       = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state   <= LSU_IDLE;
            r_granted <= 1'b0;
            r_err_acc <= 1'b0;
        end else begin
            r_state <= w_state_next;
            // Read-valid closes the access, a grant stops the request
            if (i_dbus_rvalid) begin
                r_granted <= 1'b0;
            end else if (o_dbus_req && i_dbus_gnt) begin
                r_granted <= 1'b1;
            end
            if (w_done) begin
                r_err_acc <= 1'b0;
            end else if (r_state == LSU_SPLIT_LO && i_dbus_rvalid && i_dbus_err) begin
                r_err_acc <= 1'b1;
            end
        end
    end

    // Lower word of a split load, joined with the upper word later
    always_ff @(posedge i_clk) begin
        if (r_state == LSU_SPLIT_LO && i_dbus_rvalid) begin
            r_lo_rdata <= i_dbus_rdata;
        end
    end

    // ========================================================================
    // Bus drive and results
    // ========================================================================

    assign w_use_hi     = (r_state == LSU_SPLIT_HI);
    assign o_dbus_we    = o_dbus_req && i_write;
    assign o_dbus_addr  = w_use_hi ? w_addr_hi  : w_addr_lo;
    assign o_dbus_wdata = w_use_hi ? i_hi_wdata : i_lo_wdata;
    assign o_dbus_wstrb = w_use_hi ? i_hi_wstrb : i_lo_wstrb;

    assign o_lo_rdata = r_lo_rdata;
    assign o_split_hi = w_use_hi;
    // Busy drops in the completion cycle so the caller can take the result
    assign o_busy     = w_is_mem_op && !w_done;
    assign o_err      = w_done && (i_dbus_err || r_err_acc);

    // Responder only answers accesses that were requested
    a_no_rvalid_idle : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (r_state == LSU_IDLE) |-> !i_dbus_rvalid);

    // Ungranted request holds its address into the next cycle
    a_req_addr_stable : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_dbus_req && !i_dbus_gnt) |=> (o_dbus_req && $stable(o_dbus_addr)));

endmodule : lsu_bus_seq

//--- source/lsu_load_align.sv
// Extracts the addressed bytes from one or two bus words and extends the load result
`timescale 1ns/1ns

module lsu_load_align
    import lsu_bus_pkg::*;
    import lsu_op_pkg::*;
(
    input  ls_size_e            i_size,
    input  logic [OFFS_W-1:0]   i_offset,
    // Second half of a split access in progress
    input  logic                i_split_hi,
    input  logic [DATA_W-1:0]   i_lo_rdata,
    input  logic [DATA_W-1:0]   i_dbus_rdata,
    output logic [DATA_W-1:0]   o_rdata
);

    logic [OFFS_W+2:0]   w_shift_bits;
    logic [2*DATA_W-1:0] w_combined;
    logic [2*DATA_W-1:0] w_shifted;
    logic [DATA_W-1:0]   w_raw;

    // ========================================================================
    // Byte extraction
    // ========================================================================

    assign w_shift_bits = {i_offset, 3'b000};

    // Upper word sits above the captured lower word during a split
    always_comb begin
        if (i_split_hi) begin
            w_combined = {i_dbus_rdata, i_lo_rdata};
        end else begin
            w_combined = {{DATA_W{1'b0}}, i_dbus_rdata};
        end
    end

    assign w_shifted = w_combined >> w_shift_bits;
    assign w_raw     = w_shifted[DATA_W-1:0];

    // ========================================================================
    // Extension
    // ========================================================================

    always_comb begin
        case (i_size)
            LS_BYTE:   o_rdata = {{(DATA_W-8){w_raw[7]}}, w_raw[7:0]};
            LS_BYTE_U: o_rdata = {{(DATA_W-8){1'b0}}, w_raw[7:0]};
            LS_HALF:   o_rdata = {{(DATA_W-16){w_raw[15]}}, w_raw[15:0]};
            LS_HALF_U: o_rdata = {{(DATA_W-16){1'b0}}, w_raw[15:0]};
            // Word passes through as is
            default:   o_rdata = w_raw;
        endcase
    end

endmodule : lsu_load_align

//--- source/lsu_op_pkg.sv
// Access size and sequencer state encodings, imported by the LSU modules and the testbench
package lsu_op_pkg;

    // ========================================================================
    // Access size
    // ========================================================================

    // Same values as the funct3 field of loads and stores
    typedef enum logic [2:0] {
        LS_BYTE   = 3'b000,
        LS_HALF   = 3'b001,
        LS_WORD   = 3'b010,
        LS_BYTE_U = 3'b100,
        LS_HALF_U = 3'b101
    } ls_size_e;

    // ========================================================================
    // Bus sequencer state
    // ========================================================================

    typedef enum logic [1:0] {
        // No command in flight
        LSU_IDLE     = 2'b00,
        // Single access, aligned or not crossing a word
        LSU_ALIGNED  = 2'b01,
        // Lower word of a crossing access
        LSU_SPLIT_LO = 2'b10,
        // Upper word of a crossing access
        LSU_SPLIT_HI = 2'b11
    } lsu_state_e;

endpackage : lsu_op_pkg

//--- source/lsu_store_align.sv
// Places store data and byte strobes into the lanes of the lower and upper bus words
`timescale 1ns/1ns

module lsu_store_align
    import lsu_bus_pkg::*;
    import lsu_op_pkg::*;
(
    input  ls_size_e            i_size,
    input  logic [OFFS_W-1:0]   i_offset,
    input  logic [DATA_W-1:0]   i_wdata,
    output logic [DATA_W-1:0]   o_lo_wdata,
    output logic [STRB_W-1:0]   o_lo_wstrb,
    output logic [DATA_W-1:0]   o_hi_wdata,
    output logic [STRB_W-1:0]   o_hi_wstrb
);

    // Store data cut to the access size, still in lane 0
    logic [DATA_W-1:0]   w_wdata_raw;
    logic [STRB_W-1:0]   w_wstrb_raw;

    // Offset expressed in bits
    logic [OFFS_W+2:0]   w_shift_bits;

    // Two-word window after the lane shift
    logic [2*DATA_W-1:0] w_data_win;
    logic [2*STRB_W-1:0] w_strb_win;

    // Zero-extend and build the strobe pattern
    always_comb begin
        case (i_size)
            LS_BYTE, LS_BYTE_U: begin
                w_wdata_raw = {{(DATA_W-8){1'b0}}, i_wdata[7:0]};
                w_wstrb_raw = STRB_W'(1);
            end
            LS_HALF, LS_HALF_U: begin
                w_wdata_raw = {{(DATA_W-16){1'b0}}, i_wdata[15:0]};
                w_wstrb_raw = STRB_W'(3);
            end
            default: begin
                // Full word
                w_wdata_raw = i_wdata;
                w_wstrb_raw = '1;
            end
        endcase
    end

    // Eight bits per byte of offset
    assign w_shift_bits = {i_offset, 3'b000};

    // Bytes that run past the lower word spill into the upper word
    assign w_data_win = {{DATA_W{1'b0}}, w_wdata_raw} << w_shift_bits;
    assign w_strb_win = {{STRB_W{1'b0}}, w_wstrb_raw} << i_offset;

    assign o_lo_wdata = w_data_win[DATA_W-1:0];
    assign o_lo_wstrb = w_strb_win[STRB_W-1:0];
    assign o_hi_wdata = w_data_win[2*DATA_W-1:DATA_W];
    assign o_hi_wstrb = w_strb_win[2*STRB_W-1:STRB_W];

endmodule : lsu_store_align

//--- source/lsu_top.sv
// Load/store unit top level, connects store aligner, bus sequencer and load aligner
`timescale 1ns/1ns

module lsu_top
    import lsu_bus_pkg::*;
    import lsu_op_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    // Command, held stable while busy
    input  logic                i_valid,
    input  logic                i_read,
    input  logic                i_write,
    input  ls_size_e            i_size,
    input  logic [ADDR_W-1:0]   i_addr,
    input  logic [DATA_W-1:0]   i_wdata,
    // Data bus
    output logic                o_dbus_req,
    output logic                o_dbus_we,
    output logic [ADDR_W-1:0]   o_dbus_addr,
    output logic [DATA_W-1:0]   o_dbus_wdata,
    output logic [STRB_W-1:0]   o_dbus_wstrb,
    input  logic                i_dbus_gnt,
    input  logic                i_dbus_rvalid,
    input  logic [DATA_W-1:0]   i_dbus_rdata,
    input  logic                i_dbus_err,
    // Result, valid when busy is low with a valid command
    output logic [DATA_W-1:0]   o_rdata,
    output logic                o_busy,
    output logic                o_err
);

    logic [OFFS_W-1:0] w_offset;
    logic [DATA_W-1:0] w_lo_wdata;
    logic [STRB_W-1:0] w_lo_wstrb;
    logic [DATA_W-1:0] w_hi_wdata;
    logic [STRB_W-1:0] w_hi_wstrb;
    logic [DATA_W-1:0] w_lo_rdata;
    logic              w_split_hi;

    // Byte offset shared by both aligners
    assign w_offset = i_addr[OFFS_W-1:0];

    lsu_store_align store_align_i (
        .i_size     (i_size),
        .i_offset   (w_offset),
        .i_wdata    (i_wdata),
        .o_lo_wdata (w_lo_wdata),
        .o_lo_wstrb (w_lo_wstrb),
        .o_hi_wdata (w_hi_wdata),
        .o_hi_wstrb (w_hi_wstrb)
    );

    lsu_bus_seq #(
        .ADDR_W (ADDR_W)
    ) bus_seq_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (i_valid),
        .i_read        (i_read),
        .i_write       (i_write),
        .i_size        (i_size),
        .i_addr        (i_addr),
        .i_lo_wdata    (w_lo_wdata),
        .i_lo_wstrb    (w_lo_wstrb),
        .i_hi_wdata    (w_hi_wdata),
        .i_hi_wstrb    (w_hi_wstrb),
        .i_dbus_gnt    (i_dbus_gnt),
        .i_dbus_rvalid (i_dbus_rvalid),
        .i_dbus_rdata  (i_dbus_rdata),
        .i_dbus_err    (i_dbus_err),
        .o_dbus_req    (o_dbus_req),
        .o_dbus_we     (o_dbus_we),
        .o_dbus_addr   (o_dbus_addr),
        .o_dbus_wdata  (o_dbus_wdata),
        .o_dbus_wstrb  (o_dbus_wstrb),
        .o_lo_rdata    (w_lo_rdata),
        .o_split_hi    (w_split_hi),
        .o_busy        (o_busy),
        .o_err         (o_err)
    );

    lsu_load_align load_align_i (
        .i_size       (i_size),
        .i_offset     (w_offset),
        .i_split_hi   (w_split_hi),
        .i_lo_rdata   (w_lo_rdata),
        .i_dbus_rdata (i_dbus_rdata),
        .o_rdata      (o_rdata)
    );

endmodule : lsu_top
